/* monitorPkg.sv */
//--------------------
// host register map, table depth and
// command / status bit positions of the test monitor
//--------------------
package monitorPkg;

   localparam int AddrWidth  = 4;  // host address bits
   localparam int TableDepth = 5;  // pass/fail table entries

   // host register addresses
   // the first five double as pass/fail table indices
   typedef enum logic [AddrWidth-1:0] {
      PassAddr     = 4'd0,  // always checked
      FailAddr     = 4'd1,  // always checked
      AltPassAddr  = 4'd2,  // checked when nonzero
      HostPassAddr = 4'd3,  // nonzero and checkToHost
      AltFailAddr  = 4'd4,  // checked when nonzero
      CtrlAddr     = 4'd5,
      CaptureAddr  = 4'd6,
      CmdAddr      = 4'd7,  // write-only, reads zero
      StatusAddr   = 4'd8   // read-only
   } regAddrT;

   //--------------------
   // register bit fields
   //--------------------

   // CtrlAddr
   localparam int CtrlCheckToHostBit = 0;

   // CmdAddr, both self-clearing
   localparam int CmdResetBit   = 0;  // force core into reset
   localparam int CmdTimeoutBit = 1;  // declare timeout failure

   // StatusAddr
   localparam int StatusPassBit  = 0;
   localparam int StatusFailBit  = 1;
   localparam int StatusResetBit = 2;

endpackage

/* monitorRegs.sv */
//--------------------
// host register block: pass/fail table, control and capture
// registers, command pulses and read mux
//--------------------
`timescale 1ns/1ps

module monitorRegs #(
   parameter int DataWidth  = 32,
   parameter int PcWidth    = 30,
   parameter int NumCapture = 10
) (
   input  logic                  dvtFlags,
   input  logic                  pcFail,
   input  logic                  wrEn,
   input  monitorPkg::regAddrT   addr,
   input  logic [DataWidth-1:0]  wrData,
   input  logic                  coreReset,
   input  logic                  passStatus,
   input  logic                  failStatus,
   output logic [DataWidth-1:0]  rdData,
   output logic [PcWidth-1:0]    passTable [monitorPkg::TableDepth],
   output logic                  checkToHost,
   output logic [NumCapture-1:0] captureEn,
   output logic                  cmdReset,
   output logic                  cmdTimeout
);
   import monitorPkg::*;

   logic wrCtrl;
   logic wrCapture;
   logic wrCmd;

   // write decode
   assign wrCtrl    = wrEn && (addr == CtrlAddr);
   assign wrCapture = wrEn && (addr == CaptureAddr);
   assign wrCmd     = wrEn && (addr == CmdAddr);

   //--------------------
   // pass/fail table
   //--------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         for (int i = 0; i < TableDepth; i++) begin
            passTable[i] <= '0;
         end
      end else begin
         for (int i = 0; i < TableDepth; i++) begin
            if (wrEn && (int'(addr) == i)) begin
               passTable[i] <= wrData[PcWidth-1:0];  // upper pc bits dropped
            end
         end
      end
   end

   //--------------------
   // control and capture
   //--------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         checkToHost <= 1'b0;
         captureEn   <= '0;
      end else begin
         if (wrCtrl) begin
            checkToHost <= wrData[CtrlCheckToHostBit];
         end
         if (wrCapture) begin
            captureEn <= wrData[NumCapture-1:0];
         end
      end
   end

   // command pulses, high for one cycle after the write edge
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         cmdReset   <= 1'b0;
         cmdTimeout <= 1'b0;
      end else begin
         cmdReset   <= wrCmd && wrData[CmdResetBit];
         cmdTimeout <= wrCmd && wrData[CmdTimeoutBit];
      end
   end

   //--------------------
   // read mux
   //--------------------
   always_comb begin
      rdData = '0;
      case (addr)
         CtrlAddr: begin
            rdData[CtrlCheckToHostBit] = checkToHost;
         end
         CaptureAddr: begin
            rdData[NumCapture-1:0] = captureEn;
         end
         StatusAddr: begin
            rdData[StatusPassBit]  = passStatus;
            rdData[StatusFailBit]  = failStatus;
            rdData[StatusResetBit] = coreReset;  // fed back from sleep control
         end
         default: begin
            // table entries zero-extended, CmdAddr and holes stay zero
            for (int i = 0; i < TableDepth; i++) begin
               if (int'(addr) == i) begin
                  rdData = DataWidth'(passTable[i]);
               end
            end
         end
      endcase
   end

endmodule

/* pcMatcher.sv */
//--------------------
// pass/fail address compare on the qualified pc
//--------------------
`timescale 1ns/1ps

module pcMatcher #(
   parameter int PcWidth = 30
) (
   input  logic               pcValid,
   input  logic [PcWidth-1:0] pc,
   input  logic [PcWidth-1:0] passTable [monitorPkg::TableDepth],
   input  logic               checkToHost,
   output logic               passHit,
   output logic               failHit
);
   import monitorPkg::*;

   logic [PcWidth-1:0] passEntry;
   logic [PcWidth-1:0] failEntry;
   logic [PcWidth-1:0] altPassEntry;
   logic [PcWidth-1:0] hostPassEntry;
   logic [PcWidth-1:0] altFailEntry;

   logic altPassOn;
   logic hostPassOn;
   logic altFailOn;

   assign passEntry     = passTable[int'(PassAddr)];
   assign failEntry     = passTable[int'(FailAddr)];
   assign altPassEntry  = passTable[int'(AltPassAddr)];
   assign hostPassEntry = passTable[int'(HostPassAddr)];
   assign altFailEntry  = passTable[int'(AltFailAddr)];

   // a zero entry means unused
   assign altPassOn  = (altPassEntry != '0);
   assign hostPassOn = (hostPassEntry != '0) && checkToHost;
   assign altFailOn  = (altFailEntry != '0);

   //--------------------
   // hit decode
   //--------------------
   assign passHit = pcValid &&
                    ((pc == passEntry) ||
                     (altPassOn && (pc == altPassEntry)) ||
                     (hostPassOn && (pc == hostPassEntry)));

   assign failHit = pcValid &&
                    ((pc == failEntry) ||
                     (altFailOn && (pc == altFailEntry)));

endmodule

/* coreSleepCtrl.sv */
//--------------------
// pass/fail status latch, hold-off counter and core reset
//--------------------
`timescale 1ns/1ps

module coreSleepCtrl #(
   parameter int HoldOffCycles = 20
) (
   input  logic dvtFlags,
   input  logic pcFail,
   input  logic passHit,
   input  logic failHit,
   input  logic cmdReset,
   input  logic cmdTimeout,
   output logic passStatus,
   output logic failStatus,
   output logic coreReset
);

   localparam int CntWidth = $clog2(HoldOffCycles + 1);

   typedef enum logic [1:0] {
      Idle,     // core running, waiting for a result
      HoldOff,  // result latched, counting down to sleep
      Sleep     // core held in reset
   } sleepStateT;

   sleepStateT          state;
   logic [CntWidth-1:0] holdCnt;
   logic                latchHit;

   // only the first result counts, a timeout in the same cycle wins
   assign latchHit = (state == Idle) && (passHit || failHit) &&
                     !passStatus && !failStatus && !cmdTimeout;

   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         state      <= Idle;
         holdCnt    <= '0;
         passStatus <= 1'b0;
         failStatus <= 1'b0;
         coreReset  <= 1'b0;
      end else begin
         //--------------------
         // sleep sequencing
         //--------------------
         case (state)
            Idle: begin
               if (latchHit) begin
                  state   <= HoldOff;
                  holdCnt <= CntWidth'(1);  // latch edge counts as cycle 0
               end
            end
            HoldOff: begin
               if (holdCnt == CntWidth'(HoldOffCycles)) begin
                  state     <= Sleep;
                  coreReset <= 1'b1;
               end else begin
                  holdCnt <= holdCnt + 1'b1;
               end
            end
            default: ;  // Sleep, left only by pcFail
         endcase

         // status, fail has priority on a double hit
         if (latchHit) begin
            passStatus <= passHit && !failHit;
            failStatus <= failHit;
         end
         if (cmdTimeout) begin
            passStatus <= 1'b0;
            failStatus <= 1'b1;
         end

         // host forced reset skips the hold-off
         if (cmdReset) begin
            state     <= Sleep;
            coreReset <= 1'b1;
         end
      end
   end

endmodule

/* coreTestMonitor.sv */
//--------------------
// core test monitor top: register block beside the
// pc matcher and sleep control
//--------------------
`timescale 1ns/1ps

module coreTestMonitor #(
   parameter int DataWidth     = 32,
   parameter int PcWidth       = 30,
   parameter int NumCapture    = 10,
   parameter int HoldOffCycles = 20
) (
   input  logic                  dvtFlags,
   input  logic                  pcFail,
   input  logic                  wrEn,
   input  monitorPkg::regAddrT   addr,
   input  logic [DataWidth-1:0]  wrData,
   input  logic                  pcValid,
   input  logic [PcWidth-1:0]    pc,
   output logic [DataWidth-1:0]  rdData,
   output logic [NumCapture-1:0] captureEn,
   output logic                  coreReset,
   output logic                  passStatus,
   output logic                  failStatus
);
   import monitorPkg::*;

   logic [PcWidth-1:0] passTable [TableDepth];  // regs to matcher
   logic               checkToHost;
   logic               cmdReset;
   logic               cmdTimeout;
   logic               passHit;
   logic               failHit;

   //--------------------
   // host register block
   //--------------------
   monitorRegs #(
      .DataWidth  (DataWidth),
      .PcWidth    (PcWidth),
      .NumCapture (NumCapture)
   ) u_regs (
      .dvtFlags    (dvtFlags),
      .pcFail      (pcFail),
      .wrEn        (wrEn),
      .addr        (addr),
      .wrData      (wrData),
      .coreReset   (coreReset),
      .passStatus  (passStatus),
      .failStatus  (failStatus),
      .rdData      (rdData),
      .passTable   (passTable),
      .checkToHost (checkToHost),
      .captureEn   (captureEn),
      .cmdReset    (cmdReset),
      .cmdTimeout  (cmdTimeout)
   );

   // pc compare, combinational
   pcMatcher #(
      .PcWidth (PcWidth)
   ) u_matcher (
      .pcValid     (pcValid),
      .pc          (pc),
      .passTable   (passTable),
      .checkToHost (checkToHost),
      .passHit     (passHit),
      .failHit     (failHit)
   );

   // status latch and core reset
   coreSleepCtrl #(
      .HoldOffCycles (HoldOffCycles)
   ) u_sleep (
      .dvtFlags   (dvtFlags),
      .pcFail     (pcFail),
      .passHit    (passHit),
      .failHit    (failHit),
      .cmdReset   (cmdReset),
      .cmdTimeout (cmdTimeout),
      .passStatus (passStatus),
      .failStatus (failStatus),
      .coreReset  (coreReset)
   );

endmodule

/* coreTestMonitor_props.sv */
//--------------------
// bound assertions on status and core reset behavior
//--------------------
`timescale 1ns/1ps

module coreTestMonitor_props #(
   parameter int NumCapture = 10
) (
   input logic                  dvtFlags,
   input logic                  pcFail,
   input logic                  passStatus,
   input logic                  failStatus,
   input logic                  coreReset,
   input logic [NumCapture-1:0] captureEn
);

   // one result at a time
   statusExclusive: assert property (
      @(posedge dvtFlags) disable iff (pcFail)
      !(passStatus && failStatus)
   ) else $error("passStatus and failStatus are both high");

   // a sleeping core only wakes through pcFail
   resetHeld: assert property (
      @(posedge dvtFlags) disable iff (pcFail)
      !$fell(coreReset)
   ) else $error("coreReset fell while pcFail was low");

   // capture enables come out of reset cleared
   captureCleared: assert property (
      @(posedge dvtFlags)
      $fell(pcFail) |-> (captureEn == '0)
   ) else $error("captureEn not zero right after reset release");

endmodule

bind coreTestMonitor coreTestMonitor_props #(
   .NumCapture (NumCapture)
) u_props (
   .dvtFlags   (dvtFlags),
   .pcFail     (pcFail),
   .passStatus (passStatus),
   .failStatus (failStatus),
   .coreReset  (coreReset),
   .captureEn  (captureEn)
);

/* tbClockGen.sv */
//--------------------
// testbench clock and reset generator
//--------------------
`timescale 1ns/1ps

module tbClockGen #(
   parameter int Period      = 40,
   parameter int ResetCycles = 8
) (
   input  logic resetReq,  // rising edge starts a fresh reset
   output logic dvtFlags,
   output logic pcFail
);

   initial dvtFlags = 1'b0;

   always #(Period / 2) dvtFlags = ~dvtFlags;

   // reset at start-up, then again on each request
   always begin
      pcFail = 1'b1;
      repeat (ResetCycles) @(negedge dvtFlags);
      pcFail = 1'b0;  // released on a falling edge
      @(posedge resetReq);
   end

endmodule

/* tbCoreTestMonitor.sv */
//--------------------
// testbench top with step table, xorshift source,
// value check and DUT
//--------------------
`timescale 1ns/1ps

module tbCoreTestMonitor;
   import monitorPkg::*;

   localparam int DataWidth     = 32;
   localparam int PcWidth       = 30;
   localparam int NumCapture    = 10;
   localparam int HoldOffCycles = 20;
   localparam int WaitLimit     = 200;  // cycles

   localparam logic [31:0] PcMask  = 32'((64'd1 << PcWidth) - 1);
   localparam logic [31:0] CapMask = 32'((64'd1 << NumCapture) - 1);

   // status register values as {coreReset, fail, pass}
   localparam logic [31:0] StIdle  = 32'h0;
   localparam logic [31:0] StPass  = 32'h1;
   localparam logic [31:0] StFail  = 32'h2;
   localparam logic [31:0] StPassSleep = 32'h5;
   localparam logic [31:0] StFailSleep = 32'h6;

   typedef enum logic [2:0] {
      StepWrite,
      StepRead,       // compare rdData and the status or capture outputs
      StepPc,
      StepWaitReset,  // expected = cycles since the last timer start
      StepReset
   } stepKindT;

   typedef struct packed {
      stepKindT           kind;
      regAddrT            addr;
      logic [31:0]        data;
      logic [PcWidth-1:0] pcVal;
      logic [31:0]        expected;
      logic               startTimer;
   } stepT;

   logic                  dvtFlags;
   logic                  pcFail;
   logic                  resetReq;
   logic                  wrEn;
   regAddrT               addr;
   logic [DataWidth-1:0]  wrData;
   logic                  pcValid;
   logic [PcWidth-1:0]    pc;
   logic [DataWidth-1:0]  rdData;
   logic [NumCapture-1:0] captureEn;
   logic                  coreReset;
   logic                  passStatus;
   logic                  failStatus;

   stepT        steps[$];
   logic [31:0] rngState;
   logic [31:0] tableVal [TableDepth];
   int unsigned cycleCnt = 0;
   int unsigned markCycle;

   tbClockGen #(
      .Period      (40),
      .ResetCycles (8)
   ) u_clk (
      .resetReq (resetReq),
      .dvtFlags (dvtFlags),
      .pcFail   (pcFail)
   );

   coreTestMonitor #(
      .DataWidth     (DataWidth),
      .PcWidth       (PcWidth),
      .NumCapture    (NumCapture),
      .HoldOffCycles (HoldOffCycles)
   ) u_dut (
      .dvtFlags   (dvtFlags),
      .pcFail     (pcFail),
      .wrEn       (wrEn),
      .addr       (addr),
      .wrData     (wrData),
      .pcValid    (pcValid),
      .pc         (pc),
      .rdData     (rdData),
      .captureEn  (captureEn),
      .coreReset  (coreReset),
      .passStatus (passStatus),
      .failStatus (failStatus)
   );

   always @(posedge dvtFlags) cycleCnt <= cycleCnt + 1;  // edge counter

   //--------------------
   // random source
   //--------------------
   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic logic [PcWidth-1:0] randPc();
      logic [PcWidth-1:0] v;
      v = PcWidth'(xorshift32());
      if (v == '0) begin
         v = PcWidth'(1);  // zero marks an unused entry
      end
      return v;
   endfunction

   //--------------------
   // failure reporting
   //--------------------
   task automatic stopOnFailure(input string why);
      $display("TEST FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
         stopOnFailure("value mismatch");
      end
   endtask

   //--------------------
   // step table builders
   //--------------------
   task automatic addStep(input stepKindT kind, input regAddrT a, input logic [31:0] d,
                          input logic [PcWidth-1:0] p, input logic [31:0] e,
                          input logic timer);
      stepT s;
      s.kind       = kind;
      s.addr       = a;
      s.data       = d;
      s.pcVal      = p;
      s.expected   = e;
      s.startTimer = timer;
      steps.push_back(s);
   endtask

   task automatic queueWrite(input regAddrT a, input logic [31:0] d, input logic timer);
      addStep(StepWrite, a, d, '0, '0, timer);
   endtask

   task automatic queueRead(input regAddrT a, input logic [31:0] e);
      addStep(StepRead, a, '0, '0, e, 1'b0);
   endtask

   task automatic queuePc(input logic [PcWidth-1:0] p, input logic timer);
      addStep(StepPc, PassAddr, '0, p, '0, timer);
   endtask

   task automatic buildSteps();
      logic [31:0]        d;
      logic [PcWidth-1:0] hostPc;
      logic [PcWidth-1:0] altFailPc;
      // readback of every writable register after reset
      queueRead(StatusAddr, StIdle);
      queueRead(CaptureAddr, 32'h0);
      for (int i = 0; i < TableDepth; i++) begin
         d = xorshift32();
         tableVal[i] = d;
         queueWrite(regAddrT'(4'(i)), d, 1'b0);
         queueRead(regAddrT'(4'(i)), d & PcMask);  // zero-extended pc bits
      end
      d = xorshift32();
      queueWrite(CtrlAddr, d, 1'b0);
      queueRead(CtrlAddr, d & 32'h1);
      d = xorshift32();
      queueWrite(CaptureAddr, d, 1'b0);
      queueRead(CaptureAddr, d & CapMask);
      queueRead(CmdAddr, 32'h0);

      // pass hit then an ignored fail hit and sleep after hold-off
      queuePc(PcWidth'(tableVal[int'(PassAddr)]), 1'b1);
      queueRead(StatusAddr, StPass);
      queuePc(PcWidth'(tableVal[int'(FailAddr)]), 1'b0);
      queueRead(StatusAddr, StPass);
      addStep(StepWaitReset, PassAddr, '0, '0, HoldOffCycles, 1'b0);
      queueRead(StatusAddr, StPassSleep);

      // zero AltFailAddr entry is unused
      addStep(StepReset, PassAddr, '0, '0, '0, 1'b0);
      queueWrite(PassAddr, 32'(randPc()), 1'b0);
      queueWrite(FailAddr, 32'(randPc()), 1'b0);
      queueRead(AltFailAddr, 32'h0);
      queuePc('0, 1'b0);
      queueRead(StatusAddr, StIdle);
      // nonzero AltFailAddr entry fails
      altFailPc = randPc();
      addStep(StepReset, PassAddr, '0, '0, '0, 1'b0);
      queueWrite(AltFailAddr, 32'(altFailPc), 1'b0);
      queuePc(altFailPc, 1'b0);
      queueRead(StatusAddr, StFail);

      // HostPassAddr gated by checkToHost
      hostPc = randPc();
      addStep(StepReset, PassAddr, '0, '0, '0, 1'b0);
      queueWrite(PassAddr, 32'(randPc()), 1'b0);
      queueWrite(HostPassAddr, 32'(hostPc), 1'b0);
      queueWrite(CtrlAddr, 32'h0, 1'b0);
      queuePc(hostPc, 1'b0);
      queueRead(StatusAddr, StIdle);
      queueWrite(CtrlAddr, 32'h1, 1'b0);
      queuePc(hostPc, 1'b0);
      queueRead(StatusAddr, StPass);

      // timeout and reset commands
      addStep(StepReset, PassAddr, '0, '0, '0, 1'b0);
      queueWrite(CmdAddr, 32'(1 << CmdTimeoutBit), 1'b0);
      // fail without core reset for longer than the hold-off
      for (int i = 0; i <= HoldOffCycles; i++) begin
         queueRead(StatusAddr, StFail);
      end
      queueWrite(CmdAddr, 32'(1 << CmdResetBit), 1'b1);
      addStep(StepWaitReset, PassAddr, '0, '0, 32'h1, 1'b0);
      queueRead(StatusAddr, StFailSleep);
      queueRead(StatusAddr, StFailSleep);
      addStep(StepReset, PassAddr, '0, '0, '0, 1'b0);
      queueRead(StatusAddr, StIdle);
   endtask

   //--------------------
   // step execution
   //--------------------
   task automatic waitResetRelease();
      int waited;
      waited = 0;
      while (pcFail) begin
         if (waited >= WaitLimit) begin
            $display("timeout: pcFail was never released");
            stopOnFailure("reset release timeout");
         end else begin
            @(posedge dvtFlags);
            waited++;
         end
      end
      @(negedge dvtFlags);  // back on the drive edge
   endtask

   task automatic applyReset();
      resetReq = 1'b1;
      @(negedge dvtFlags);
      resetReq = 1'b0;
      waitResetRelease();
   endtask

   task automatic runStep(input stepT s);
      int waited;
      case (s.kind)
         StepWrite: begin
            addr   = s.addr;
            wrData = s.data;
            wrEn   = 1'b1;
            @(negedge dvtFlags);
            wrEn = 1'b0;
            if (s.startTimer) markCycle = cycleCnt;
         end
         StepRead: begin
            addr = s.addr;
            @(negedge dvtFlags);
            checkValue("rdData", rdData, s.expected);
            if (s.addr == StatusAddr) begin
               checkValue("{coreReset,failStatus,passStatus}",
                          {29'h0, coreReset, failStatus, passStatus}, s.expected);
            end
            if (s.addr == CaptureAddr) begin
               checkValue("captureEn", 32'(captureEn), s.expected);
            end
         end
         StepPc: begin
            pc      = s.pcVal;
            pcValid = 1'b1;
            @(negedge dvtFlags);
            pcValid = 1'b0;
            if (s.startTimer) markCycle = cycleCnt;  // status latch edge
         end
         StepWaitReset: begin
            waited = 0;
            while (!coreReset) begin
               if (waited >= WaitLimit) begin
                  $display("timeout: coreReset never rose");
                  stopOnFailure("core reset timeout");
               end else begin
                  @(negedge dvtFlags);
                  waited++;
               end
            end
            checkValue("coreReset delay", cycleCnt - markCycle, s.expected);
         end
         default: applyReset();
      endcase
   endtask

   initial begin
      rngState  = 32'hbb8e28e3;
      resetReq  = 1'b0;
      wrEn      = 1'b0;
      addr      = PassAddr;
      wrData    = '0;
      pcValid   = 1'b0;
      pc        = '0;
      markCycle = 0;
      buildSteps();
      @(negedge dvtFlags);
      waitResetRelease();
      foreach (steps[i]) begin
         runStep(steps[i]);
      end
      $display("%0d steps applied", steps.size());
      $display("TEST PASS");
      $finish;
   end

endmodule

/* files.f */
monitorPkg.sv
monitorRegs.sv
pcMatcher.sv
coreSleepCtrl.sv
coreTestMonitor.sv
coreTestMonitor_props.sv
tbClockGen.sv
tbCoreTestMonitor.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tbCoreTestMonitor -f files.f -o simTb \
   && ./obj_dir/simTb | tee /dev/stderr | grep -qx "TEST PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
